//--- Makefile
# Verilator build and run of the machine timer testbench.

SIM      ?= verilator
FLAGS    ?= --binary --timing --assert -j 0
TOP      ?= clint_tb
FILELIST ?= clint_top.f
BUILD    ?= obj_dir
RUNFLAGS ?= +verilator+error+limit+1000
PASS_MSG := Simulation passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

# The run passes only if the pass line shows up in the simulator output.
test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) $(RUNFLAGS) | tee /dev/stderr | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD)

//--- clint_top.f
+incdir+include
verilog/clint_pkg.sv
verilog/clint_reg_if.sv
verilog/clint_access_ctrl.sv
verilog/tick_prescaler.sv
verilog/mtime_timer.sv
verilog/clint_top.sv
sim/clint_clk_gen.sv
sim/clint_chk.sv
sim/clint_tb.sv

//--- include/clint_defs.svh
// ==========================================================================
// Shared constants of the machine timer: register offsets, tick divider
// and data widths. Included by every design file that needs them.
// ==========================================================================

`ifndef CLINT_DEFS_SVH
`define CLINT_DEFS_SVH

// ==========================================================================
// Widths
// ==========================================================================
`define CLINT_BUS_W 32                 // Width of the core data port.
`define CLINT_REG_W 64                 // Width of mtime and mtimecmp.

// ==========================================================================
// Register map, byte offsets on addr_i
// ==========================================================================
`define CLINT_OFF_MTIME_LO 4'h0
`define CLINT_OFF_MTIME_HI 4'h4
`define CLINT_OFF_CMP_LO   4'h8
`define CLINT_OFF_CMP_HI   4'hC

`define CLINT_TICK_DIV 4               // Clock cycles per mtime increment.

`endif

//--- sim/clint_chk.sv
// ==========================================================================
// Concurrent assertions on the timer top level, bound into clint_top.
// ==========================================================================

`timescale 1ns/1ps
`default_nettype none

`include "clint_defs.svh"

module clint_chk (
    input logic        clk,
    input logic        reset_n,
    input logic        en_i,
    input logic [3:0]  we_i,
    input logic [3:0]  addr_i,
    input logic [31:0] data_i,
    input logic        mti_o,
    input logic [63:0] mtime_o,
    input logic        tick_i
);

    int          fail_cnt = 0;            // Read by the testbench at the end.
    logic [63:0] cmp_model;               // mtimecmp as rebuilt from port writes.
    logic [31:0] stg_lo;
    logic [3:0]  stg_be;
    logic        stg_vld;
    logic        mtime_wr;

    assign mtime_wr = en_i && (we_i != 4'b0000) && (addr_i == `CLINT_OFF_MTIME_HI);

    function automatic logic [63:0] merge_cmp(
        input logic [63:0] old_v,
        input logic [31:0] lo,
        input logic [3:0]  lo_be,
        input logic [31:0] hi,
        input logic [3:0]  hi_be
    );
        logic [63:0] res;
        res = old_v;
        for (int i = 0; i < 4; i++) begin
            if (lo_be[i]) begin
                res[8*i +: 8] = lo[8*i +: 8];
            end
            if (hi_be[i]) begin
                res[32+8*i +: 8] = hi[8*i +: 8];
            end
        end
        return res;
    endfunction

    // ======================================================================
    // Write model of mtimecmp
    // ======================================================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            stg_vld   <= 1'b0;
            stg_lo    <= '0;
            stg_be    <= '0;
            cmp_model <= '0;
        end else if (en_i && (we_i != 4'b0000)) begin
            case (addr_i)
                `CLINT_OFF_CMP_LO: begin
                    stg_vld <= 1'b1;
                    stg_lo  <= data_i;
                    stg_be  <= we_i;
                end
                `CLINT_OFF_CMP_HI: begin
                    cmp_model <= merge_cmp(cmp_model, stg_lo, stg_vld ? stg_be : 4'b0000,
                                           data_i, we_i);
                    stg_vld   <= 1'b0;
                end
                `CLINT_OFF_MTIME_LO, `CLINT_OFF_MTIME_HI: stg_vld <= 1'b0;  // Staged half lost.
                default: ;
            endcase
        end
    end

    // ======================================================================
    // Assertions
    // ======================================================================
    a_mti_reset: assert property (@(posedge clk) $rose(reset_n) |-> !mti_o)
        else begin
            fail_cnt++;
            $error("mti_o is high in the first cycle after reset");
        end

    a_mtime_step: assert property (@(posedge clk) disable iff (!reset_n)
        (mtime_o != $past(mtime_o)) |->
            (($past(tick_i) && (mtime_o == $past(mtime_o) + 64'd1)) || $past(mtime_wr)))
        else begin
            fail_cnt++;
            $error("mtime_o changed without a tick or a write");
        end

    a_mti_follow: assert property (@(posedge clk) disable iff (!reset_n)
        $past(reset_n) |-> (mti_o == $past(mtime_o >= cmp_model)))
        else begin
            fail_cnt++;
            $error("mti_o does not follow the compare of mtime and mtimecmp");
        end

endmodule

bind clint_top clint_chk chk_i (
    .clk     (clk),
    .reset_n (reset_n),
    .en_i    (en_i),
    .we_i    (we_i),
    .addr_i  (addr_i),
    .data_i  (data_i),
    .mti_o   (mti_o),
    .mtime_o (mtime_o),
    .tick_i  (tick)
);

`default_nettype wire

//--- sim/clint_clk_gen.sv
// ==========================================================================
// Testbench clock and reset source: free-running clk, reset_n held low
// for the first cycles.
// ==========================================================================

`timescale 1ns/1ps
`default_nettype none

module clint_clk_gen #(
    parameter int PERIOD_NS    = 40,      // Clock period.
    parameter int RESET_CYCLES = 3        // Rising edges seen with reset low.
) (
    output logic clk_o,
    output logic reset_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    initial begin
        reset_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #1 reset_n_o = 1'b1;              // Released just after an edge, like other inputs.
    end

endmodule

`default_nettype wire

//--- sim/clint_tb.sv
// ==========================================================================
// Testbench of the machine timer. Runs reset, time base, atomic access,
// snapshot and interrupt tests over the 32-bit port.
// ==========================================================================

`timescale 1ns/1ps
`default_nettype none

`include "clint_defs.svh"

module clint_tb;

    localparam int DIV    = `CLINT_TICK_DIV;
    localparam int AHEAD  = 4;                      // Ticks from mtime to mtimecmp in test 6.
    localparam int GAP    = 5 * DIV + 3;
    localparam int WAIT6  = (AHEAD + 3) * DIV + 4;
    localparam int SNAP_N = 24;                     // Low and high read pairs in test 5.
    localparam int LEN    = 3 + 4 + (GAP + 2) + (8 + 2 * DIV) + 5
                          + (2 + DIV + SNAP_N * (DIV + 2)) + (7 + WAIT6);
    localparam int WATCHDOG_NS = LEN * 2 * 40;

    logic        clk;
    logic        reset_n;
    logic        en_i;
    logic [3:0]  we_i;
    logic [3:0]  addr_i;
    logic [31:0] data_i;
    logic [31:0] data_o;
    logic        mti_o;
    logic [63:0] mtime_o;

    int          edge_cnt   = 0;                    // Rising edges since reset release.
    int          err_cnt    = 0;
    int          err_mark   = 0;
    int          test_cnt   = 0;
    int          ok_cnt     = 0;
    logic [31:0] rng        = 32'd63;
    logic [63:0] mtime_base = '0;                   // Last value written to mtime.
    int          base_edge  = 0;                    // Edge at which that write landed.
    logic [63:0] cmp_val    = '0;

    clint_clk_gen #(.PERIOD_NS(40), .RESET_CYCLES(3)) clk_gen_i (
        .clk_o     (clk),
        .reset_n_o (reset_n)
    );

    clint_top dut_i (
        .clk     (clk),
        .reset_n (reset_n),
        .en_i    (en_i),
        .we_i    (we_i),
        .addr_i  (addr_i),
        .data_i  (data_i),
        .data_o  (data_o),
        .mti_o   (mti_o),
        .mtime_o (mtime_o)
    );

    always @(posedge clk) begin
        if (reset_n) begin
            edge_cnt <= edge_cnt + 1;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] rand_word();
        rng = xorshift32(rng);
        return rng;
    endfunction

    // Increments applied up to edge n; the first lands DIV + 1 edges after reset.
    function automatic int ticks_through(input int n);
        return (n < 1) ? 0 : (n - 1) / DIV;
    endfunction

    function automatic logic [63:0] mtime_at(input int n);
        return mtime_base + 64'(ticks_through(n) - ticks_through(base_edge));
    endfunction

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic write_word(input logic [3:0] addr, input logic [31:0] data);
        en_i   = 1'b1;
        we_i   = 4'hF;
        addr_i = addr;
        data_i = data;
        wait_cycles(1);
        en_i   = 1'b0;
        we_i   = 4'h0;
    endtask

    task automatic read_word(input logic [3:0] addr, output logic [31:0] data);
        en_i   = 1'b1;
        we_i   = 4'h0;
        addr_i = addr;
        wait_cycles(1);
        en_i   = 1'b0;
        data   = data_o;                            // Registered at the sampling edge.
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic expect_read(input logic [3:0] addr, input string name,
                               input logic [31:0] exp);
        logic [31:0] got;
        read_word(addr, got);
        check_value(name, 64'(got), 64'(exp));
    endtask

    task automatic close_test(input string name);
        test_cnt++;
        if (err_cnt == err_mark) begin
            ok_cnt++;
            $display("Test %0d %s: ok", test_cnt, name);
        end else begin
            $display("Test %0d %s: %0d errors", test_cnt, name, err_cnt - err_mark);
        end
        err_mark = err_cnt;
    endtask

    // ======================================================================
    // Test sequence
    // ======================================================================
    initial begin
        logic [31:0] lo;
        logic [31:0] hi;
        logic [63:0] exp;
        logic [63:0] wval;
        int          e0;
        logic        seen;
        int          total_err;
        en_i   = 1'b0;
        we_i   = 4'h0;
        addr_i = 4'h0;
        data_i = 32'h0;
        @(posedge reset_n);

        check_value("mti_o", 64'(mti_o), 64'd0);
        expect_read(`CLINT_OFF_MTIME_LO, "mtime_lo", 32'h0);
        expect_read(`CLINT_OFF_MTIME_HI, "mtime_hi", 32'h0);
        expect_read(`CLINT_OFF_CMP_LO, "mtimecmp_lo", 32'h0);
        expect_read(`CLINT_OFF_CMP_HI, "mtimecmp_hi", 32'h0);
        close_test("reset values");

        read_word(`CLINT_OFF_MTIME_LO, lo);
        e0 = edge_cnt;
        wait_cycles(GAP);
        check_value("mtime_o", mtime_o, mtime_at(edge_cnt));
        read_word(`CLINT_OFF_MTIME_LO, hi);
        e0 = edge_cnt - e0;                         // Cycles between the two samples.
        if ((hi - lo) != 32'(e0 / DIV) && (hi - lo) != 32'((e0 + DIV - 1) / DIV)) begin
            $display("Mismatch mtime_lo delta: got 0x%h over %0d cycles, expected 0x%h",
                     hi - lo, e0, 32'(e0 / DIV));
            err_cnt++;
        end
        close_test("time base");

        wval = {rand_word(), rand_word()};
        write_word(`CLINT_OFF_MTIME_LO, wval[31:0]);
        write_word(`CLINT_OFF_MTIME_HI, wval[63:32]);
        mtime_base = wval;
        base_edge  = edge_cnt;
        wait_cycles(2 * DIV);
        read_word(`CLINT_OFF_MTIME_LO, lo);
        exp = mtime_at(edge_cnt - 1);
        check_value("mtime_lo", 64'(lo), 64'(exp[31:0]));
        expect_read(`CLINT_OFF_MTIME_HI, "mtime_hi", exp[63:32]);
        cmp_val = {rand_word(), rand_word()};
        write_word(`CLINT_OFF_CMP_LO, cmp_val[31:0]);
        write_word(`CLINT_OFF_CMP_HI, cmp_val[63:32]);
        expect_read(`CLINT_OFF_CMP_LO, "mtimecmp_lo", cmp_val[31:0]);
        expect_read(`CLINT_OFF_CMP_HI, "mtimecmp_hi", cmp_val[63:32]);
        close_test("atomic write");

        write_word(`CLINT_OFF_CMP_LO, rand_word());
        write_word(`CLINT_OFF_MTIME_LO, rand_word());  // Drops the staged mtimecmp half.
        cmp_val[63:32] = rand_word();
        write_word(`CLINT_OFF_CMP_HI, cmp_val[63:32]);  // Only the upper lanes land.
        expect_read(`CLINT_OFF_CMP_LO, "mtimecmp_lo", cmp_val[31:0]);
        expect_read(`CLINT_OFF_CMP_HI, "mtimecmp_hi", cmp_val[63:32]);
        close_test("discarded staging");

        write_word(`CLINT_OFF_MTIME_LO, 32'hFFFF_FFF0);
        write_word(`CLINT_OFF_MTIME_HI, 32'h0);
        mtime_base = 64'h0000_0000_FFFF_FFF0;
        base_edge  = edge_cnt;
        seen       = 1'b0;
        // Each low read samples on an increment edge, so a carry falls between the pair.
        for (int i = 0; i < SNAP_N; i++) begin
            while (edge_cnt % DIV != 0) begin
                wait_cycles(1);
            end
            read_word(`CLINT_OFF_MTIME_LO, lo);
            exp = mtime_at(edge_cnt - 1);
            read_word(`CLINT_OFF_MTIME_HI, hi);
            check_value("mtime_lo", 64'(lo), 64'(exp[31:0]));
            check_value("mtime_hi", 64'(hi), 64'(exp[63:32]));
            seen |= (hi == 32'd1);
        end
        if (!seen) begin
            $display("The mtime low word never wrapped during the snapshot test");
            err_cnt++;
        end
        close_test("snapshot");

        cmp_val = mtime_at(edge_cnt) + 64'(AHEAD);
        write_word(`CLINT_OFF_CMP_LO, cmp_val[31:0]);
        write_word(`CLINT_OFF_CMP_HI, cmp_val[63:32]);
        wait_cycles(1);
        check_value("mti_o", 64'(mti_o), 64'd0);
        seen = 1'b0;
        for (int i = 0; i < WAIT6; i++) begin
            wait_cycles(1);
            check_value("mti_o", 64'(mti_o), 64'(mtime_at(edge_cnt - 1) >= cmp_val));
            seen |= mti_o;
        end
        if (!seen) begin
            $display("mti_o never went high after mtime reached mtimecmp");
            err_cnt++;
        end
        write_word(`CLINT_OFF_CMP_LO, 32'hFFFF_FFFF);
        write_word(`CLINT_OFF_CMP_HI, 32'hFFFF_FFFF);
        cmp_val = '1;
        wait_cycles(1);
        check_value("mti_o", 64'(mti_o), 64'd0);
        expect_read(`CLINT_OFF_CMP_HI, "mtimecmp_hi", 32'hFFFF_FFFF);
        close_test("interrupt");

        total_err = err_cnt + dut_i.chk_i.fail_cnt;
        $display("Tests run %0d, ok %0d, check errors %0d, assertion failures %0d",
                 test_cnt, ok_cnt, err_cnt, dut_i.chk_i.fail_cnt);
        if (total_err == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns before the tests finished", WATCHDOG_NS);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/clint_access_ctrl.sv
// ==========================================================================
// Turns 32-bit port accesses into atomic 64-bit register accesses. Low-half
// writes are staged, low-half reads snapshot the high half.
// ==========================================================================

`timescale 1ns/1ps
`default_nettype none

`include "clint_defs.svh"

module clint_access_ctrl
    import clint_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    en_i,
    input  logic [3:0]              we_i,
    input  logic [3:0]              addr_i,
    input  logic [`CLINT_BUS_W-1:0] data_i,
    output logic [`CLINT_BUS_W-1:0] data_o,
    clint_reg_if.ctrl               bus
);

    // ======================================================================
    // Address decode
    // ======================================================================
    logic     hit_mtime_lo;
    logic     hit_mtime_hi;
    logic     hit_cmp_lo;
    logic     hit_cmp_hi;
    logic     addr_ok;
    logic     acc_hi;
    reg_sel_e acc_sel;
    logic     is_wr;
    logic     is_rd;

    assign hit_mtime_lo = (addr_i == `CLINT_OFF_MTIME_LO);
    assign hit_mtime_hi = (addr_i == `CLINT_OFF_MTIME_HI);
    assign hit_cmp_lo   = (addr_i == `CLINT_OFF_CMP_LO);
    assign hit_cmp_hi   = (addr_i == `CLINT_OFF_CMP_HI);

    assign addr_ok = hit_mtime_lo | hit_mtime_hi | hit_cmp_lo | hit_cmp_hi;
    assign acc_hi  = hit_mtime_hi | hit_cmp_hi;
    assign acc_sel = (hit_cmp_lo | hit_cmp_hi) ? SEL_CMP : SEL_MTIME;

    assign is_wr = en_i && addr_ok && (we_i != 4'b0000);  // Unaligned offsets are ignored.
    assign is_rd = en_i && addr_ok && (we_i == 4'b0000);

    // ======================================================================
    // Write staging
    // ======================================================================
    wr_state_e               state_q;
    logic [`CLINT_BUS_W-1:0] stage_data_q;
    logic [3:0]              stage_be_q;
    logic                    stage_hit;

    // The staged low half only pairs with a high write to the same register.
    assign stage_hit = ((state_q == STAGED_MTIME) && (acc_sel == SEL_MTIME)) ||
                       ((state_q == STAGED_CMP)   && (acc_sel == SEL_CMP));

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state_q <= IDLE;
        end else if (is_wr) begin
            if (acc_hi) begin
                state_q <= IDLE;                  // High half commits and clears.
            end else if (acc_sel == SEL_CMP) begin
                state_q <= STAGED_CMP;            // Any older staged half is dropped.
            end else begin
                state_q <= STAGED_MTIME;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (is_wr && !acc_hi) begin
            stage_data_q <= data_i;
            stage_be_q   <= we_i;
        end
    end

    // Only high-half writes reach the registers; low lanes ride along when staged.
    assign bus.wr_en = is_wr && acc_hi;
    assign bus.sel   = acc_sel;
    assign bus.be    = stage_hit ? {we_i, stage_be_q} : {we_i, 4'b0000};
    assign bus.wdata = {data_i, stage_data_q};

    // ======================================================================
    // Read path with high-half snapshot
    // ======================================================================
    logic [`CLINT_REG_W-1:0] live;
    logic [`CLINT_BUS_W-1:0] shadow_q;
    logic                    shadow_vld_q;
    reg_sel_e                shadow_sel_q;

    assign live = (acc_sel == SEL_CMP) ? bus.mtimecmp : bus.mtime;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            data_o       <= '0;
            shadow_vld_q <= 1'b0;
            shadow_sel_q <= SEL_MTIME;
        end else if (is_rd) begin
            if (!acc_hi) begin
                data_o       <= live[`CLINT_BUS_W-1:0];
                shadow_vld_q <= 1'b1;             // Snapshot now names this register.
                shadow_sel_q <= acc_sel;
            end else if (shadow_vld_q && (shadow_sel_q == acc_sel)) begin
                data_o       <= shadow_q;         // Coherent with the earlier low read.
                shadow_vld_q <= 1'b0;
            end else begin
                data_o       <= live[`CLINT_REG_W-1:`CLINT_BUS_W];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (is_rd && !acc_hi) begin
            shadow_q <= live[`CLINT_REG_W-1:`CLINT_BUS_W];
        end
    end

endmodule

`default_nettype wire

//--- verilog/clint_pkg.sv
// ==========================================================================
// Types shared by the timer blocks. Imported by wildcard in module headers.
// ==========================================================================

`default_nettype none

package clint_pkg;

    // ======================================================================
    // Register select
    // ======================================================================
    typedef enum logic {
        SEL_MTIME = 1'b0,              // Access targets mtime.
        SEL_CMP   = 1'b1               // Access targets mtimecmp.
    } reg_sel_e;

    // ======================================================================
    // Write staging states
    // ======================================================================
    // A low-half write parks in one of the staged states until the high
    // half of the same register arrives and both land together.
    typedef enum logic [1:0] {
        IDLE         = 2'd0,           // Nothing staged.
        STAGED_MTIME = 2'd1,           // Low word of mtime is held.
        STAGED_CMP   = 2'd2            // Low word of mtimecmp is held.
    } wr_state_e;

endpackage

`default_nettype wire

//--- verilog/clint_reg_if.sv
// ==========================================================================
// 64-bit register access path between the access controller and the
// timer registers, with the live register values coming back.
// ==========================================================================

`timescale 1ns/1ps
`default_nettype none

`include "clint_defs.svh"

interface clint_reg_if
    import clint_pkg::*;
();

    logic                        wr_en;     // One-cycle commit strobe.
    reg_sel_e                    sel;       // Target register of the write.
    logic [`CLINT_REG_W/8-1:0]   be;        // Byte enables over 64 bits.
    logic [`CLINT_REG_W-1:0]     wdata;     // Write data, both halves.
    logic [`CLINT_REG_W-1:0]     mtime;     // Live mtime value.
    logic [`CLINT_REG_W-1:0]     mtimecmp;  // Live mtimecmp value.

    // Controller side issues writes and samples the live values.
    modport ctrl (
        output wr_en, sel, be, wdata,
        input  mtime, mtimecmp
    );

    // Register side applies writes and exposes its contents.
    modport regs (
        input  wr_en, sel, be, wdata,
        output mtime, mtimecmp
    );

endinterface

`default_nettype wire

//--- verilog/clint_top.sv
// ==========================================================================
// Machine timer top level. The core connects its memory-mapped port and
// takes mti_o and mtime_o for the interrupt and the time CSR.
// ==========================================================================

`timescale 1ns/1ps
`default_nettype none

`include "clint_defs.svh"

module clint_top (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    en_i,
    input  logic [3:0]              we_i,
    input  logic [3:0]              addr_i,
    input  logic [`CLINT_BUS_W-1:0] data_i,
    output logic [`CLINT_BUS_W-1:0] data_o,
    output logic                    mti_o,
    output logic [`CLINT_REG_W-1:0] mtime_o
);

    clint_reg_if reg_bus ();                      // Controller to timer registers.

    logic tick;                                   // One pulse per mtime increment.

    clint_access_ctrl access_ctrl_i (
        .clk     (clk),
        .reset_n (reset_n),
        .en_i    (en_i),
        .we_i    (we_i),
        .addr_i  (addr_i),
        .data_i  (data_i),
        .data_o  (data_o),
        .bus     (reg_bus.ctrl)
    );

    tick_prescaler #(
        .DIV (`CLINT_TICK_DIV)
    ) prescaler_i (
        .clk     (clk),
        .reset_n (reset_n),
        .tick_o  (tick)
    );

    mtime_timer timer_i (
        .clk     (clk),
        .reset_n (reset_n),
        .tick_i  (tick),
        .regs    (reg_bus.regs),
        .mti_o   (mti_o),
        .mtime_o (mtime_o)
    );

endmodule

`default_nettype wire

//--- verilog/mtime_timer.sv
// ==========================================================================
// Holds mtime and mtimecmp, applies byte-lane writes, advances mtime on
// each tick and raises the registered timer interrupt.
// ==========================================================================

`timescale 1ns/1ps
`default_nettype none

`include "clint_defs.svh"

module mtime_timer
    import clint_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    tick_i,
    clint_reg_if.regs               regs,
    output logic                    mti_o,
    output logic [`CLINT_REG_W-1:0] mtime_o
);

    // ======================================================================
    // Byte-lane merge
    // ======================================================================
    // Enabled lanes take the new data, the rest keep the old value.
    function automatic logic [`CLINT_REG_W-1:0] merge_lanes(
        input logic [`CLINT_REG_W-1:0]   old_v,
        input logic [`CLINT_REG_W-1:0]   new_v,
        input logic [`CLINT_REG_W/8-1:0] be
    );
        logic [`CLINT_REG_W-1:0] res;
        res = old_v;
        for (int i = 0; i < `CLINT_REG_W / 8; i++) begin
            if (be[i]) begin
                res[8*i +: 8] = new_v[8*i +: 8];
            end
        end
        return res;
    endfunction

    logic [`CLINT_REG_W-1:0] mtime_q;
    logic [`CLINT_REG_W-1:0] mtimecmp_q;
    logic                    mtime_wr;
    logic                    cmp_wr;

    assign mtime_wr = regs.wr_en && (regs.sel == SEL_MTIME);
    assign cmp_wr   = regs.wr_en && (regs.sel == SEL_CMP);

    // ======================================================================
    // Registers
    // ======================================================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mtime_q <= '0;
        end else if (mtime_wr) begin
            mtime_q <= merge_lanes(mtime_q, regs.wdata, regs.be);  // Wins over the tick.
        end else if (tick_i) begin
            mtime_q <= mtime_q + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mtimecmp_q <= '0;
        end else if (cmp_wr) begin
            mtimecmp_q <= merge_lanes(mtimecmp_q, regs.wdata, regs.be);
        end
    end

    // ======================================================================
    // Compare and interrupt
    // ======================================================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mti_o <= 1'b0;
        end else begin
            mti_o <= (mtime_q >= mtimecmp_q);     // Level stays up while due.
        end
    end

    assign regs.mtime    = mtime_q;
    assign regs.mtimecmp = mtimecmp_q;
    assign mtime_o       = mtime_q;               // Feeds the core's time CSR.

endmodule

`default_nettype wire

//--- verilog/tick_prescaler.sv
// ==========================================================================
// Divides clk down to the one-cycle tick pulse that advances mtime.
// ==========================================================================

`timescale 1ns/1ps
`default_nettype none

`include "clint_defs.svh"

module tick_prescaler #(
    parameter int DIV = `CLINT_TICK_DIV    // Cycles per tick, 1 or more.
) (
    input  logic clk,
    input  logic reset_n,
    output logic tick_o
);

    // A divide by one still needs a one-bit counter.
    localparam int CNT_W = (DIV > 1) ? $clog2(DIV) : 1;

    logic [CNT_W-1:0] cnt_q;
    logic             wrap;

    assign wrap = (cnt_q == CNT_W'(DIV - 1));     // Last cycle of the period.

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            cnt_q  <= '0;
            tick_o <= 1'b0;
        end else begin
            tick_o <= wrap;                       // First pulse DIV cycles after reset.
            if (wrap) begin
                cnt_q <= '0;
            end else begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire
